// File: verilog/rv_hazard_pkg.sv
package rv_hazard_pkg;

  // Architectural register index where x0 is hardwired to zero and never a hazard
  typedef logic [4:0] reg_idx_t;

  // Kind of result an instruction writes back
  // Only ALU and PC results are available early enough for the forwarding unit
  typedef enum logic [2:0] {
    RES_ALU  = 3'd0,
    RES_LOAD = 3'd1,
    RES_CSR  = 3'd2,
    RES_M    = 3'd3,
    RES_PC   = 3'd4
  } res_src_t;

  // Selection of the next PC in the fetch stage
  typedef enum logic [1:0] {
    PC_SEL_SEQ       = 2'd0,
    PC_SEL_PREDICTED = 2'd1,
    PC_SEL_REDIRECT  = 2'd2
  } pc_sel_t;

  // Memory styles of the data path
  localparam int MEM_TYPE_SRAM = 0;
  localparam int MEM_TYPE_BRAM = 1;

  // An external forwarding unit resolves ALU results from EX and MEM
  localparam int FWD = 1;

  // The register file does not bypass its write port to its read ports,
  // so a consumer in ID must wait until a WB producer has retired
  localparam int FWD_REGFILE = 0;

  // With BRAM the read data only shows up in WB
  localparam int MEM_TYPE = MEM_TYPE_BRAM;

  // The PC register sits behind the redirect mux, so one wrong-path fetch slips through
  localparam int PC_REG = 1;

endpackage

// File: verilog/rv_stage_track.sv
`timescale 1ns/100ps

// Tracks the destination register and result kind of the instructions that
// currently occupy EX, MEM and WB
module rv_stage_track (
  input  logic                    clk,
  input  logic                    arst_n,

  // Issue handshake from the ID stage
  input  logic                    id_valid,
  input  logic                    id_ready,
  input  rv_hazard_pkg::reg_idx_t rd_id,
  input  logic                    reg_write_id,
  input  rv_hazard_pkg::res_src_t res_id,

  // Pipeline control from the merge block
  input  logic                    id_ex_flush,
  input  logic                    ex_mem_flush,
  input  logic                    op_active_ex,

  // Stage contents
  output rv_hazard_pkg::reg_idx_t rd_ex,
  output logic                    reg_write_ex,
  output rv_hazard_pkg::res_src_t res_ex,
  output rv_hazard_pkg::reg_idx_t rd_mem,
  output logic                    reg_write_mem,
  output rv_hazard_pkg::res_src_t res_mem,
  output rv_hazard_pkg::reg_idx_t rd_wb,
  output logic                    reg_write_wb
);

  // An instruction leaves ID on a cycle where both sides of the handshake agree
  logic accept_id;

  assign accept_id = id_valid && id_ready;

  // Valid bits of the three stages
  // A bubble is represented by a cleared reg_write, which is all the
  // hazard logic looks at
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reg_write_ex  <= 1'b0;
      reg_write_mem <= 1'b0;
      reg_write_wb  <= 1'b0;
    end else begin
      // A multi-cycle operation keeps EX occupied
      // The hold wins over a flush because the instruction in EX is older
      // than anything a flush removes from the ID/EX boundary
      if (!op_active_ex) begin
        reg_write_ex <= accept_id && reg_write_id && !id_ex_flush;
      end

      // MEM receives a bubble on a redirect from MEM and while EX is busy,
      // so the held EX instruction is not duplicated into MEM
      reg_write_mem <= reg_write_ex && !ex_mem_flush;

      // WB always retires whatever MEM held
      reg_write_wb  <= reg_write_mem;
    end
  end

  // Destination and kind travel alongside the valid bits
  // They only matter while the matching reg_write is high
  always_ff @(posedge clk) begin
    if (!op_active_ex && accept_id) begin
      rd_ex  <= rd_id;
      res_ex <= res_id;
    end

    rd_mem  <= rd_ex;
    res_mem <= res_ex;

    // WB result kind is not needed since every WB producer is treated alike
    rd_wb   <= rd_mem;
  end

endmodule

// File: verilog/rv_data_hazard.sv
`timescale 1ns/100ps

// Read-after-write detection between the ID sources and the destinations in
// EX, MEM and WB
// Only the cases that the forwarding unit cannot cover raise a stall
module rv_data_hazard (
  // ID stage sources
  input  rv_hazard_pkg::reg_idx_t rs1_id,
  input  rv_hazard_pkg::reg_idx_t rs2_id,
  input  logic                    rs1_used_id,
  input  logic                    rs2_used_id,

  // Stage contents from the tracker
  input  rv_hazard_pkg::reg_idx_t rd_ex,
  input  logic                    reg_write_ex,
  input  rv_hazard_pkg::res_src_t res_ex,
  input  rv_hazard_pkg::reg_idx_t rd_mem,
  input  logic                    reg_write_mem,
  input  rv_hazard_pkg::res_src_t res_mem,
  input  rv_hazard_pkg::reg_idx_t rd_wb,
  input  logic                    reg_write_wb,

  output logic                    raw_stall
);

  // True when a used source reads the destination of a writing producer
  // Writes to x0 are discarded, so they never create a dependency
  function automatic logic src_match(
    input rv_hazard_pkg::reg_idx_t rd,
    input logic                    wr,
    input rv_hazard_pkg::reg_idx_t rs1,
    input logic                    rs1_used,
    input rv_hazard_pkg::reg_idx_t rs2,
    input logic                    rs2_used
  );
    logic hit;
    hit = (rs1_used && (rs1 == rd)) || (rs2_used && (rs2 == rd));
    return wr && (rd != '0) && hit;
  endfunction

  // Whether a producer's result is still unavailable to the forwarding path
  // CSR and M results only appear in WB on every memory style
  // Load data is late only when the memory is BRAM
  function automatic logic late_result(input rv_hazard_pkg::res_src_t res);
    logic late_load;
    late_load = (res == rv_hazard_pkg::RES_LOAD) &&
                (rv_hazard_pkg::MEM_TYPE != rv_hazard_pkg::MEM_TYPE_SRAM);
    return late_load || (res == rv_hazard_pkg::RES_CSR) || (res == rv_hazard_pkg::RES_M);
  endfunction

  logic ex_match;
  logic mem_match;
  logic wb_match;
  logic wb_stall;
  logic fwd_stall;
  logic all_stall;

  assign ex_match  = src_match(rd_ex, reg_write_ex, rs1_id, rs1_used_id, rs2_id, rs2_used_id);
  assign mem_match = src_match(rd_mem, reg_write_mem, rs1_id, rs1_used_id, rs2_id, rs2_used_id);
  assign wb_match  = src_match(rd_wb, reg_write_wb, rs1_id, rs1_used_id, rs2_id, rs2_used_id);

  // Without a register-file bypass the consumer would read the stale value
  // while the producer is writing, so WB matches stall in both modes
  assign wb_stall = (rv_hazard_pkg::FWD_REGFILE == 0) && wb_match;

  // Forwarding case
  // ALU and PC results in EX and MEM are picked up by the forwarding unit
  assign fwd_stall = (ex_match && late_result(res_ex)) ||
                     (mem_match && late_result(res_mem)) ||
                     wb_stall;

  // Without forwarding every dependency waits for the register file
  assign all_stall = ex_match || mem_match || wb_stall;

  assign raw_stall = (rv_hazard_pkg::FWD != 0) ? fwd_stall : all_stall;

endmodule

// File: verilog/rv_ctrl_hazard.sv
`timescale 1ns/100ps

// Control hazard requests from the PC mux and the MEM stage redirect
module rv_ctrl_hazard (
  input  logic                   clk,
  input  logic                   arst_n,

  input  rv_hazard_pkg::pc_sel_t pc_sel,
  input  logic                   redirect_valid_mem,

  // Source of a taken prediction in the current cycle, aligned with the PC mux
  input  logic                   btb_pred_taken,
  input  logic                   ras_pred_taken,

  output logic                   control_flush,
  output logic                   pred_req,
  output logic                   redirect_pending
);

  logic pc_redirect;
  logic pc_predicted;
  logic late_pred;

  assign pc_redirect  = (pc_sel == rv_hazard_pkg::PC_SEL_REDIRECT);
  assign pc_predicted = (pc_sel == rv_hazard_pkg::PC_SEL_PREDICTED);

  // A taken branch or jump in EX, or a misprediction found in MEM, throws
  // away everything younger than the redirecting instruction
  assign control_flush = pc_redirect || redirect_valid_mem;

  // A BTB hit steers fetch before the sequential instruction is fetched, so
  // nothing needs to go
  // RAS and static predictions are made in ID, one fetch too late
  assign late_pred = !btb_pred_taken || ras_pred_taken;
  assign pred_req  = pc_predicted && late_pred;

  // With a registered PC the fetch in the redirect cycle still follows the
  // old path, so the flush is stretched by one cycle
  // The flag follows only the live request, which keeps it to a single cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      redirect_pending <= 1'b0;
    end else begin
      redirect_pending <= (rv_hazard_pkg::PC_REG != 0) && control_flush;
    end
  end

endmodule

// File: verilog/rv_hazard_merge.sv
`timescale 1ns/100ps

// Combines the data and control hazard results into the handshake and
// flush outputs of the pipeline
module rv_hazard_merge (
  input  logic raw_stall,
  input  logic control_flush,
  input  logic pred_req,
  input  logic redirect_pending,
  input  logic redirect_valid_mem,
  input  logic op_active_ex,

  output logic data_hazard_id,
  output logic id_ready,
  output logic if_id_flush,
  output logic id_ex_flush,
  output logic ex_mem_flush
);

  logic advancing;

  // The instruction in ID is flushed on a redirect, so its dependency no
  // longer matters and the redirect must not be blocked by it
  assign data_hazard_id = raw_stall && !control_flush;

  // ID hands over an instruction only when it is free of hazards and EX can take it
  assign advancing = !data_hazard_id && !op_active_ex;
  assign id_ready  = advancing;

  // A late prediction only discards the fetched instruction once the
  // predicting instruction actually leaves ID
  assign if_id_flush = control_flush || redirect_pending || (pred_req && advancing);

  assign id_ex_flush = control_flush || redirect_pending;

  // MEM gets a bubble on a MEM redirect and while EX is held
  assign ex_mem_flush = redirect_valid_mem || op_active_ex;

endmodule

// File: verilog/rv_pipe_ctrl.sv
`timescale 1ns/100ps

// Hazard control of the five-stage pipeline
// The data and control paths run side by side and meet in the merge block
module rv_pipe_ctrl (
  input  logic                    clk,
  input  logic                    arst_n,

  // Issue handshake with the ID stage
  input  logic                    id_valid,
  output logic                    id_ready,
  input  rv_hazard_pkg::reg_idx_t rs1_id,
  input  rv_hazard_pkg::reg_idx_t rs2_id,
  input  logic                    rs1_used_id,
  input  logic                    rs2_used_id,
  input  rv_hazard_pkg::reg_idx_t rd_id,
  input  logic                    reg_write_id,
  input  rv_hazard_pkg::res_src_t res_id,

  // Control inputs
  input  logic                    op_active_ex,
  input  rv_hazard_pkg::pc_sel_t  pc_sel,
  input  logic                    redirect_valid_mem,
  input  logic                    btb_pred_taken,
  input  logic                    ras_pred_taken,

  // Hazard and flush outputs
  output logic                    data_hazard_id,
  output logic                    if_id_flush,
  output logic                    id_ex_flush,
  output logic                    ex_mem_flush,

  // Stage contents
  output rv_hazard_pkg::reg_idx_t rd_ex,
  output logic                    reg_write_ex,
  output rv_hazard_pkg::res_src_t res_ex,
  output rv_hazard_pkg::reg_idx_t rd_mem,
  output logic                    reg_write_mem,
  output rv_hazard_pkg::res_src_t res_mem,
  output rv_hazard_pkg::reg_idx_t rd_wb,
  output logic                    reg_write_wb
);

  logic raw_stall;
  logic control_flush;
  logic pred_req;
  logic redirect_pending;

  // Stage tracking closes the loop through id_ready and the flushes
  rv_stage_track u_stage_track (
    .clk          (clk),
    .arst_n       (arst_n),
    .id_valid     (id_valid),
    .id_ready     (id_ready),
    .rd_id        (rd_id),
    .reg_write_id (reg_write_id),
    .res_id       (res_id),
    .id_ex_flush  (id_ex_flush),
    .ex_mem_flush (ex_mem_flush),
    .op_active_ex (op_active_ex),
    .rd_ex        (rd_ex),
    .reg_write_ex (reg_write_ex),
    .res_ex       (res_ex),
    .rd_mem       (rd_mem),
    .reg_write_mem(reg_write_mem),
    .res_mem      (res_mem),
    .rd_wb        (rd_wb),
    .reg_write_wb (reg_write_wb)
  );

  rv_data_hazard u_data_hazard (
    .rs1_id       (rs1_id),
    .rs2_id       (rs2_id),
    .rs1_used_id  (rs1_used_id),
    .rs2_used_id  (rs2_used_id),
    .rd_ex        (rd_ex),
    .reg_write_ex (reg_write_ex),
    .res_ex       (res_ex),
    .rd_mem       (rd_mem),
    .reg_write_mem(reg_write_mem),
    .res_mem      (res_mem),
    .rd_wb        (rd_wb),
    .reg_write_wb (reg_write_wb),
    .raw_stall    (raw_stall)
  );

  rv_ctrl_hazard u_ctrl_hazard (
    .clk               (clk),
    .arst_n            (arst_n),
    .pc_sel            (pc_sel),
    .redirect_valid_mem(redirect_valid_mem),
    .btb_pred_taken    (btb_pred_taken),
    .ras_pred_taken    (ras_pred_taken),
    .control_flush     (control_flush),
    .pred_req          (pred_req),
    .redirect_pending  (redirect_pending)
  );

  rv_hazard_merge u_hazard_merge (
    .raw_stall         (raw_stall),
    .control_flush     (control_flush),
    .pred_req          (pred_req),
    .redirect_pending  (redirect_pending),
    .redirect_valid_mem(redirect_valid_mem),
    .op_active_ex      (op_active_ex),
    .data_hazard_id    (data_hazard_id),
    .id_ready          (id_ready),
    .if_id_flush       (if_id_flush),
    .id_ex_flush       (id_ex_flush),
    .ex_mem_flush      (ex_mem_flush)
  );

endmodule

// File: verification/tb_rv_pipe_ctrl.sv
`timescale 1ns/100ps

// Directed and random tests of the pipeline hazard control
// A shadow model of EX, MEM and WB predicts every DUT output in each cycle
module tb_rv_pipe_ctrl;

  localparam int CLK_PERIOD      = 4;
  localparam int RESET_CYCLES    = 16;
  localparam int DIRECTED_CYCLES = 100;
  localparam int RANDOM_CYCLES   = 400;
  localparam int MARGIN_CYCLES   = 100;
  localparam int WAIT_LIMIT      = 20;

  logic                    clk;
  logic                    arst_n;
  logic                    id_valid;
  logic                    id_ready;
  rv_hazard_pkg::reg_idx_t rs1_id;
  rv_hazard_pkg::reg_idx_t rs2_id;
  logic                    rs1_used_id;
  logic                    rs2_used_id;
  rv_hazard_pkg::reg_idx_t rd_id;
  logic                    reg_write_id;
  rv_hazard_pkg::res_src_t res_id;
  logic                    op_active_ex;
  rv_hazard_pkg::pc_sel_t  pc_sel;
  logic                    redirect_valid_mem;
  logic                    btb_pred_taken;
  logic                    ras_pred_taken;
  logic                    data_hazard_id;
  logic                    if_id_flush;
  logic                    id_ex_flush;
  logic                    ex_mem_flush;
  rv_hazard_pkg::reg_idx_t rd_ex;
  logic                    reg_write_ex;
  rv_hazard_pkg::res_src_t res_ex;
  rv_hazard_pkg::reg_idx_t rd_mem;
  logic                    reg_write_mem;
  rv_hazard_pkg::res_src_t res_mem;
  rv_hazard_pkg::reg_idx_t rd_wb;
  logic                    reg_write_wb;

  // Shadow copy of the stage contents and the redirect-pending flag
  logic                    m_wr_ex;
  logic                    m_wr_mem;
  logic                    m_wr_wb;
  logic                    m_pending;
  rv_hazard_pkg::reg_idx_t m_rd_ex;
  rv_hazard_pkg::reg_idx_t m_rd_mem;
  rv_hazard_pkg::reg_idx_t m_rd_wb;
  rv_hazard_pkg::res_src_t m_res_ex;
  rv_hazard_pkg::res_src_t m_res_mem;

  int          errors;
  int          checks;
  int          test_base;
  logic        settled;
  logic [31:0] rng;

  rv_pipe_ctrl DUT (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // A used ID source reads the destination of a writing producer other than x0
  function automatic logic depends(input rv_hazard_pkg::reg_idx_t rd, input logic wr);
    return wr && (rd != 5'd0) &&
           ((rs1_used_id && (rs1_id == rd)) || (rs2_used_id && (rs2_id == rd)));
  endfunction

  // Results the forwarding unit cannot take from EX or MEM
  function automatic logic late_kind(input rv_hazard_pkg::res_src_t res);
    logic bram_load;
    bram_load = (res == rv_hazard_pkg::RES_LOAD) &&
                (rv_hazard_pkg::MEM_TYPE == rv_hazard_pkg::MEM_TYPE_BRAM);
    return bram_load || (res == rv_hazard_pkg::RES_CSR) || (res == rv_hazard_pkg::RES_M);
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_reg_idx(input string name, input rv_hazard_pkg::reg_idx_t got,
                               input rv_hazard_pkg::reg_idx_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_res_src(input string name, input rv_hazard_pkg::res_src_t got,
                               input rv_hazard_pkg::res_src_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  // Inputs change on the falling edge and outputs are sampled 1 ns later
  task automatic settle();
    if (!settled) begin
      #1;
      settled = 1'b1;
    end
  endtask

  task automatic check_stages();
    check_bit("reg_write_ex", reg_write_ex, m_wr_ex);
    check_bit("reg_write_mem", reg_write_mem, m_wr_mem);
    check_bit("reg_write_wb", reg_write_wb, m_wr_wb);
    // Destination fields only carry meaning behind a set reg_write
    if (m_wr_ex) begin
      check_reg_idx("rd_ex", rd_ex, m_rd_ex);
      check_res_src("res_ex", res_ex, m_res_ex);
    end
    if (m_wr_mem) begin
      check_reg_idx("rd_mem", rd_mem, m_rd_mem);
      check_res_src("res_mem", res_mem, m_res_mem);
    end
    if (m_wr_wb) begin
      check_reg_idx("rd_wb", rd_wb, m_rd_wb);
    end
  endtask

  // One clock cycle that checks all outputs, advances the model and returns the handshake
  task automatic cycle(output logic accepted);
    logic raw;
    logic cflush;
    logic dh;
    logic rdy;
    logic pred;
    logic idex;
    logic exmem;
    settle();
    raw    = (depends(m_rd_ex, m_wr_ex) && late_kind(m_res_ex)) ||
             (depends(m_rd_mem, m_wr_mem) && late_kind(m_res_mem)) ||
             depends(m_rd_wb, m_wr_wb);
    cflush = (pc_sel == rv_hazard_pkg::PC_SEL_REDIRECT) || redirect_valid_mem;
    dh     = raw && !cflush;
    rdy    = !dh && !op_active_ex;
    pred   = (pc_sel == rv_hazard_pkg::PC_SEL_PREDICTED) && (!btb_pred_taken || ras_pred_taken);
    idex   = cflush || m_pending;
    exmem  = redirect_valid_mem || op_active_ex;
    check_bit("data_hazard_id", data_hazard_id, dh);
    check_bit("id_ready", id_ready, rdy);
    check_bit("if_id_flush", if_id_flush, idex || (pred && rdy));
    check_bit("id_ex_flush", id_ex_flush, idex);
    check_bit("ex_mem_flush", ex_mem_flush, exmem);
    check_stages();
    accepted = id_valid && id_ready;
    // Oldest stage first so every stage sees the previous contents
    m_wr_wb   = m_wr_mem;
    m_rd_wb   = m_rd_mem;
    m_wr_mem  = m_wr_ex && !exmem;
    m_rd_mem  = m_rd_ex;
    m_res_mem = m_res_ex;
    if (!op_active_ex) begin
      m_wr_ex = id_valid && rdy && reg_write_id && !idex;
      if (id_valid && rdy) begin
        m_rd_ex  = rd_id;
        m_res_ex = res_id;
      end
    end
    m_pending = (rv_hazard_pkg::PC_REG != 0) && cflush;
    @(negedge clk);
    settled = 1'b0;
  endtask

  task automatic run(input int n);
    logic acc;
    repeat (n) cycle(acc);
  endtask

  task automatic issue(input rv_hazard_pkg::reg_idx_t rd, input logic wr,
                       input rv_hazard_pkg::res_src_t res,
                       input rv_hazard_pkg::reg_idx_t rs1, input logic used1,
                       input rv_hazard_pkg::reg_idx_t rs2, input logic used2);
    id_valid     = 1'b1;
    rd_id        = rd;
    reg_write_id = wr;
    res_id       = res;
    rs1_id       = rs1;
    rs1_used_id  = used1;
    rs2_id       = rs2;
    rs2_used_id  = used2;
  endtask

  task automatic idle();
    id_valid     = 1'b0;
    reg_write_id = 1'b0;
    rs1_used_id  = 1'b0;
    rs2_used_id  = 1'b0;
  endtask

  // Runs until the offered instruction is taken and checks how long it waited
  task automatic wait_accept(input int stalls_exp);
    logic acc;
    int   stalls;
    stalls = 0;
    acc    = 1'b0;
    while (!acc && stalls <= WAIT_LIMIT) begin
      cycle(acc);
      if (!acc) stalls++;
    end
    if (!acc) begin
      errors++;
      $display("The instruction in ID was never accepted, at %0t", $time);
    end else if (stalls != stalls_exp) begin
      errors++;
      $display("The instruction in ID waited %0d cycles instead of %0d", stalls, stalls_exp);
    end
  endtask

  task automatic begin_test();
    test_base = errors;
  endtask

  task automatic end_test(input string name);
    $display("%s finished with %0d errors", name, errors - test_base);
  endtask

  task automatic reset_state();
    begin_test();
    settle();
    check_bit("data_hazard_id", data_hazard_id, 1'b0);
    check_bit("id_ready", id_ready, 1'b1);
    check_bit("if_id_flush", if_id_flush, 1'b0);
    check_bit("id_ex_flush", id_ex_flush, 1'b0);
    check_bit("ex_mem_flush", ex_mem_flush, 1'b0);
    check_bit("reg_write_ex", reg_write_ex, 1'b0);
    check_bit("reg_write_mem", reg_write_mem, 1'b0);
    check_bit("reg_write_wb", reg_write_wb, 1'b0);
    run(2);
    end_test("reset_state");
  endtask

  task automatic alu_forwarding();
    begin_test();
    issue(5'd5, 1'b1, rv_hazard_pkg::RES_ALU, 5'd0, 1'b0, 5'd0, 1'b0);
    wait_accept(0);
    // Producer in EX is forwarded
    issue(5'd6, 1'b1, rv_hazard_pkg::RES_ALU, 5'd5, 1'b1, 5'd0, 1'b0);
    settle();
    check_bit("data_hazard_id", data_hazard_id, 1'b0);
    wait_accept(0);
    // Producer in MEM with the dependency through rs2
    issue(5'd7, 1'b1, rv_hazard_pkg::RES_ALU, 5'd0, 1'b0, 5'd5, 1'b1);
    settle();
    check_bit("data_hazard_id", data_hazard_id, 1'b0);
    wait_accept(0);
    // Producer in WB and the register file has no bypass
    issue(5'd9, 1'b1, rv_hazard_pkg::RES_ALU, 5'd5, 1'b1, 5'd0, 1'b0);
    settle();
    check_bit("data_hazard_id", data_hazard_id, 1'b1);
    wait_accept(1);
    idle();
    run(3);
    // Writes to x0 never create a dependency
    issue(5'd0, 1'b1, rv_hazard_pkg::RES_LOAD, 5'd0, 1'b0, 5'd0, 1'b0);
    wait_accept(0);
    issue(5'd10, 1'b1, rv_hazard_pkg::RES_ALU, 5'd0, 1'b1, 5'd0, 1'b1);
    settle();
    check_bit("data_hazard_id", data_hazard_id, 1'b0);
    wait_accept(0);
    // Sources that are not read never stall
    issue(5'd8, 1'b1, rv_hazard_pkg::RES_LOAD, 5'd0, 1'b0, 5'd0, 1'b0);
    wait_accept(0);
    issue(5'd11, 1'b1, rv_hazard_pkg::RES_ALU, 5'd8, 1'b0, 5'd8, 1'b0);
    settle();
    check_bit("data_hazard_id", data_hazard_id, 1'b0);
    wait_accept(0);
    idle();
    run(3);
    end_test("alu_forwarding");
  endtask

  task automatic late_use_case(input rv_hazard_pkg::res_src_t kind);
    issue(5'd12, 1'b1, kind, 5'd0, 1'b0, 5'd0, 1'b0);
    wait_accept(0);
    issue(5'd13, 1'b1, rv_hazard_pkg::RES_ALU, 5'd12, 1'b1, 5'd0, 1'b0);
    settle();
    check_bit("data_hazard_id", data_hazard_id, 1'b1);
    // Held while the producer is in EX, MEM and WB
    wait_accept(3);
    idle();
    settle();
    check_bit("reg_write_ex", reg_write_ex, 1'b1);
    check_reg_idx("rd_ex", rd_ex, 5'd13);
    check_bit("reg_write_mem", reg_write_mem, 1'b0);
    run(3);
  endtask

  task automatic late_result_use();
    begin_test();
    late_use_case(rv_hazard_pkg::RES_LOAD);
    late_use_case(rv_hazard_pkg::RES_CSR);
    late_use_case(rv_hazard_pkg::RES_M);
    end_test("late_result_use");
  endtask

  task automatic redirect_flush();
    begin_test();
    issue(5'd14, 1'b1, rv_hazard_pkg::RES_LOAD, 5'd0, 1'b0, 5'd0, 1'b0);
    wait_accept(0);
    issue(5'd15, 1'b1, rv_hazard_pkg::RES_ALU, 5'd14, 1'b1, 5'd0, 1'b0);
    settle();
    check_bit("data_hazard_id", data_hazard_id, 1'b1);
    run(1);
    // Redirect from EX while the load is in MEM
    pc_sel = rv_hazard_pkg::PC_SEL_REDIRECT;
    settle();
    check_bit("data_hazard_id", data_hazard_id, 1'b0);
    check_bit("if_id_flush", if_id_flush, 1'b1);
    check_bit("id_ex_flush", id_ex_flush, 1'b1);
    run(1);
    pc_sel = rv_hazard_pkg::PC_SEL_SEQ;
    idle();
    settle();
    check_bit("if_id_flush", if_id_flush, 1'b1);
    check_bit("id_ex_flush", id_ex_flush, 1'b1);
    check_bit("reg_write_ex", reg_write_ex, 1'b0);
    run(1);
    // Misprediction found in MEM bubbles the younger instruction in EX
    issue(5'd16, 1'b1, rv_hazard_pkg::RES_ALU, 5'd0, 1'b0, 5'd0, 1'b0);
    settle();
    check_bit("if_id_flush", if_id_flush, 1'b0);
    check_bit("id_ex_flush", id_ex_flush, 1'b0);
    wait_accept(0);
    issue(5'd17, 1'b1, rv_hazard_pkg::RES_ALU, 5'd0, 1'b0, 5'd0, 1'b0);
    wait_accept(0);
    idle();
    redirect_valid_mem = 1'b1;
    settle();
    check_bit("ex_mem_flush", ex_mem_flush, 1'b1);
    run(1);
    redirect_valid_mem = 1'b0;
    settle();
    check_bit("reg_write_mem", reg_write_mem, 1'b0);
    check_bit("reg_write_wb", reg_write_wb, 1'b1);
    check_reg_idx("rd_wb", rd_wb, 5'd16);
    run(4);
    end_test("redirect_flush");
  endtask

  task automatic prediction_hold();
    begin_test();
    pc_sel         = rv_hazard_pkg::PC_SEL_PREDICTED;
    btb_pred_taken = 1'b1;
    settle();
    check_bit("if_id_flush", if_id_flush, 1'b0);
    run(1);
    ras_pred_taken = 1'b1;
    settle();
    check_bit("if_id_flush", if_id_flush, 1'b1);
    run(1);
    // Static prediction from neither BTB nor RAS
    btb_pred_taken = 1'b0;
    ras_pred_taken = 1'b0;
    settle();
    check_bit("if_id_flush", if_id_flush, 1'b1);
    run(1);
    pc_sel = rv_hazard_pkg::PC_SEL_SEQ;
    issue(5'd18, 1'b1, rv_hazard_pkg::RES_LOAD, 5'd0, 1'b0, 5'd0, 1'b0);
    wait_accept(0);
    issue(5'd20, 1'b1, rv_hazard_pkg::RES_ALU, 5'd18, 1'b1, 5'd0, 1'b0);
    pc_sel = rv_hazard_pkg::PC_SEL_PREDICTED;
    settle();
    check_bit("data_hazard_id", data_hazard_id, 1'b1);
    check_bit("if_id_flush", if_id_flush, 1'b0);
    wait_accept(3);
    pc_sel = rv_hazard_pkg::PC_SEL_SEQ;
    issue(5'd19, 1'b1, rv_hazard_pkg::RES_ALU, 5'd0, 1'b0, 5'd0, 1'b0);
    wait_accept(0);
    // Multi-cycle operation holds EX and empties MEM
    issue(5'd21, 1'b1, rv_hazard_pkg::RES_ALU, 5'd0, 1'b0, 5'd0, 1'b0);
    op_active_ex = 1'b1;
    pc_sel       = rv_hazard_pkg::PC_SEL_PREDICTED;
    settle();
    check_bit("if_id_flush", if_id_flush, 1'b0);
    check_bit("ex_mem_flush", ex_mem_flush, 1'b1);
    check_bit("id_ready", id_ready, 1'b0);
    run(1);
    settle();
    check_bit("reg_write_ex", reg_write_ex, 1'b1);
    check_reg_idx("rd_ex", rd_ex, 5'd19);
    check_bit("reg_write_mem", reg_write_mem, 1'b0);
    run(1);
    op_active_ex = 1'b0;
    pc_sel       = rv_hazard_pkg::PC_SEL_SEQ;
    wait_accept(0);
    idle();
    settle();
    check_reg_idx("rd_ex", rd_ex, 5'd21);
    check_reg_idx("rd_mem", rd_mem, 5'd19);
    check_bit("reg_write_mem", reg_write_mem, 1'b1);
    run(3);
    end_test("prediction_hold");
  endtask

  task automatic random_stream();
    logic acc;
    logic hold;
    begin_test();
    hold = 1'b0;
    repeat (RANDOM_CYCLES) begin
      rng = xorshift(rng);
      // An offered instruction stays unchanged until it is taken
      if (!hold) begin
        id_valid     = (rng[1:0] != 2'b00);
        rd_id        = {2'b00, rng[4:2]};
        rs1_id       = {2'b00, rng[7:5]};
        rs2_id       = {2'b00, rng[10:8]};
        rs1_used_id  = rng[11];
        rs2_used_id  = rng[12];
        reg_write_id = rng[13] | rng[14];
        res_id       = rv_hazard_pkg::res_src_t'(rng[17:15] % 3'd5);
      end
      op_active_ex       = (rng[20:18] == 3'b000);
      redirect_valid_mem = (rng[25:21] == 5'b00000);
      cycle(acc);
      hold = id_valid && !acc;
    end
    idle();
    op_active_ex       = 1'b0;
    redirect_valid_mem = 1'b0;
    run(3);
    end_test("random_stream");
  endtask

  // Budget covers reset, the directed tests and the random run
  initial begin
    #((RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("Watchdog expired before all tests completed");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    clk                = 1'b0;
    arst_n             = 1'b0;
    rd_id              = '0;
    rs1_id             = '0;
    rs2_id             = '0;
    res_id             = rv_hazard_pkg::RES_ALU;
    op_active_ex       = 1'b0;
    pc_sel             = rv_hazard_pkg::PC_SEL_SEQ;
    redirect_valid_mem = 1'b0;
    btb_pred_taken     = 1'b0;
    ras_pred_taken     = 1'b0;
    idle();
    errors    = 0;
    checks    = 0;
    settled   = 1'b0;
    rng       = 32'hef0a;
    m_wr_ex   = 1'b0;
    m_wr_mem  = 1'b0;
    m_wr_wb   = 1'b0;
    m_pending = 1'b0;
    m_rd_ex   = '0;
    m_rd_mem  = '0;
    m_rd_wb   = '0;
    m_res_ex  = rv_hazard_pkg::RES_ALU;
    m_res_mem = rv_hazard_pkg::RES_ALU;
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;
    reset_state();
    alu_forwarding();
    late_result_use();
    redirect_flush();
    prediction_hold();
    random_stream();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: sources.f
verilog/rv_hazard_pkg.sv
verilog/rv_stage_track.sv
verilog/rv_data_hazard.sv
verilog/rv_ctrl_hazard.sv
verilog/rv_hazard_merge.sv
verilog/rv_pipe_ctrl.sv
verification/tb_rv_pipe_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the hazard control testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f sources.f --top-module tb_rv_pipe_ctrl -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "TEST OK" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
